//--- Bender.yml
package:
  name: team_08

sources:
  - include_dirs:
      - .
    files:
      - t08_pkg.sv
      - t08_lcd_bus.sv
      - t08_touch_reader.sv
      - t08_display_fetch.sv
      - t08_wb_arbiter.sv
      - team_08.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_touch_model.sv
      - tb_team_08.sv

//--- list.f
+incdir+.
t08_pkg.sv
t08_lcd_bus.sv
t08_touch_reader.sv
t08_display_fetch.sv
t08_wb_arbiter.sv
team_08.sv
tb_touch_model.sv
tb_team_08.sv

//--- t08_display_fetch.sv
// Display fetch
// Sends RAMWR, then streams the frame buffer word by word from memory to
// the LCD bus, most significant byte first
`timescale 1ns/100ps
`default_nettype none
`include "t08_params.svh"

module t08_display_fetch import t08_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    input  logic      en,
    input  logic      sample_stored,
    output logic      disp_req,
    output wb_addr_t  disp_addr,
    input  logic      disp_done,
    input  wb_data_t  rdata,
    output logic      byte_strobe,
    output logic      byte_is_cmd,
    output logic      frame_active,
    output lcd_byte_t byte_data,
    input  logic      lcd_busy
);
    localparam int idx_w = $clog2(`T08_FB_WORDS + 1);

    fetch_state_e     state;
    logic             pending;
    logic [idx_w-1:0] word_idx;
    logic [1:0]       byte_idx;
    wb_data_t         word_buf;
    logic             last_word;

    assign last_word   = word_idx == idx_w'(`T08_FB_WORDS - 1);
    assign disp_req    = state == fetch_read;
    // Word i sits at base plus 4i
    assign disp_addr   = wb_addr_t'(`T08_FB_BASE) + wb_addr_t'({word_idx, 2'b00});
    assign byte_is_cmd = state == fetch_cmd;
    assign byte_strobe = (state == fetch_cmd || state == fetch_send) && !lcd_busy;
    // Byte 0 is bits 31:24
    assign byte_data   = byte_is_cmd ? lcd_byte_t'(`T08_LCD_RAMWR)
                                     : word_buf[{~byte_idx, 3'b000} +: 8];
    // Held until the last write pulse has finished
    assign frame_active = state != fetch_idle || lcd_busy;

    always_ff @(posedge clk) begin
        if (!rst_n || !en) begin
            // Refresh owed as soon as the block runs again
            state    <= fetch_idle;
            pending  <= 1'b1;
            word_idx <= '0;
            byte_idx <= '0;
        end else begin
            // New samples during a frame collapse into one refresh
            if (sample_stored) pending <= 1'b1;
            else if (state == fetch_idle) pending <= 1'b0;
            case (state)
                fetch_idle: if (pending) state <= fetch_cmd;
                fetch_cmd: begin
                    if (!lcd_busy) begin
                        word_idx <= '0;
                        state    <= fetch_read;
                    end
                end
                fetch_read: begin
                    if (disp_done) begin
                        byte_idx <= '0;
                        state    <= fetch_send;
                    end
                end
                default: begin
                    if (!lcd_busy) begin
                        byte_idx <= byte_idx + 1'b1;
                        if (byte_idx == 2'd3) begin
                            if (last_word) begin
                                state <= fetch_idle;
                            end else begin
                                word_idx <= word_idx + 1'b1;
                                state    <= fetch_read;
                            end
                        end
                    end
                end
            endcase
        end
    end

    // Word buffer
    always_ff @(posedge clk) begin
        if (state == fetch_read && disp_done) word_buf <= rdata;
    end

endmodule

`default_nettype wire

//--- t08_lcd_bus.sv
// LCD bus
// Write-only 8080-style byte port, one low and one high phase of wrx per byte
`timescale 1ns/100ps
`default_nettype none

module t08_lcd_bus import t08_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    input  logic      en,
    input  logic      byte_strobe,
    input  logic      byte_is_cmd,
    input  logic      frame_active,
    input  lcd_byte_t byte_data,
    output logic      lcd_busy,
    output logic      wrx,
    output logic      csx,
    output logic      dcx,
    output lcd_byte_t lcd_data
);
    // Set during the wrx high phase after a write
    logic hold;

    // Panel selected for the whole frame
    assign csx = !frame_active;

    // Busy across both write phases
    assign lcd_busy = !wrx || hold;

    always_ff @(posedge clk) begin
        if (!rst_n || !en) begin
            wrx  <= 1'b1;
            hold <= 1'b0;
            dcx  <= 1'b1;
        end else begin
            // Low for the cycle after a strobe
            wrx  <= !byte_strobe;
            hold <= !wrx;
            // Command bytes go out with dcx low
            if (byte_strobe) dcx <= !byte_is_cmd;
        end
    end

    // Data held until the next byte
    always_ff @(posedge clk) begin
        if (byte_strobe) lcd_data <= byte_data;
    end

endmodule

`default_nettype wire

//--- t08_params.svh
// Touch-to-LCD user block parameters
// Bus widths, memory map, I2C timing and LCD command codes
`ifndef T08_PARAMS_SVH
`define T08_PARAMS_SVH

// Wishbone master widths
`define T08_WB_AW 32
`define T08_WB_DW 32

// Word address of the stored touch sample
`define T08_TOUCH_BASE 32'h3000_0000

// Frame buffer start and length in words
`define T08_FB_BASE 32'h3000_1000
`define T08_FB_WORDS 16

// Clocks per SCL half period
`define T08_I2C_DIV 4

// Touch controller address and first X register
`define T08_TOUCH_ADDR 7'h38
`define T08_TOUCH_REG 8'h03

// LCD memory write command
`define T08_LCD_RAMWR 8'h2C

`endif

//--- t08_pkg.sv
// Touch-to-LCD user block types
// Bus vectors, coordinate width and the FSM encodings
`default_nettype none
`include "t08_params.svh"

package t08_pkg;

    // Wishbone vectors
    typedef logic [`T08_WB_AW-1:0] wb_addr_t;
    typedef logic [`T08_WB_DW-1:0] wb_data_t;
    typedef logic [`T08_WB_DW/8-1:0] wb_sel_t;

    // Parallel LCD data byte
    typedef logic [7:0] lcd_byte_t;

    // One touch axis, 12 bits from the controller
    typedef logic [11:0] coord_t;

    // Touch reader sequence
    typedef enum logic [3:0] {
        i2c_idle, i2c_start, i2c_addr, i2c_reg, i2c_restart,
        i2c_raddr, i2c_read, i2c_stop, i2c_store
    } i2c_state_e;

    // Display fetch sequence
    typedef enum logic [1:0] {fetch_idle, fetch_cmd, fetch_read, fetch_send} fetch_state_e;

    // Current Wishbone owner
    typedef enum logic [1:0] {grant_none, grant_touch, grant_display} grant_e;

endpackage

`default_nettype wire

//--- t08_touch_reader.sv
// Touch reader
// I2C master that reads one X/Y pair from the touch controller on each
// falling interrupt, then asks the arbiter to store the packed sample
`timescale 1ns/100ps
`default_nettype none
`include "t08_params.svh"

module t08_touch_reader import t08_pkg::*; (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     en,
    input  logic     touch_int,
    input  logic     sda_in,
    output logic     sda_out,
    output logic     sda_oeb,
    output logic     scl,
    output logic     touch_req,
    output wb_addr_t touch_addr,
    output wb_data_t touch_wdata,
    input  logic     touch_done
);
    localparam int div_w = $clog2(`T08_I2C_DIV);

    i2c_state_e       state;
    logic [div_w-1:0] div_cnt;
    logic             tick;
    logic             half;
    logic [3:0]       bit_cnt;
    logic [1:0]       byte_cnt;
    logic [7:0]       shift;
    logic [31:0]      rx_word;
    logic [2:0]       int_sync;
    logic [1:0]       sda_sync;
    logic             int_fall;
    logic             sda_bit;
    coord_t           x_coord;
    coord_t           y_coord;

    // Open drain, only ever pulls low
    assign sda_out  = 1'b0;
    assign tick     = div_cnt == div_w'(`T08_I2C_DIV - 1);
    assign int_fall = int_sync[2] && !int_sync[1];

    // XH, XL, YH, YL arrive in that order
    assign x_coord     = {rx_word[27:24], rx_word[23:16]};
    assign y_coord     = {rx_word[11:8], rx_word[7:0]};
    assign touch_addr  = `T08_TOUCH_BASE;
    assign touch_wdata = {4'b0000, y_coord, 4'b0000, x_coord};
    assign touch_req   = state == i2c_store;

    // SDA level for the low half of the current bit, 1 releases the line
    always_comb begin
        case (state)
            i2c_addr, i2c_reg, i2c_raddr: sda_bit = (bit_cnt == 4'd8) ? 1'b1 : shift[7];
            // ACK every byte but the last
            i2c_read: sda_bit = (bit_cnt == 4'd8) ? (byte_cnt == 2'd3) : 1'b1;
            i2c_stop: sda_bit = 1'b0;
            default:  sda_bit = 1'b1;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n || !en) begin
            state    <= i2c_idle;
            scl      <= 1'b1;
            sda_oeb  <= 1'b1;
            half     <= 1'b1;
            div_cnt  <= '0;
            bit_cnt  <= '0;
            byte_cnt <= '0;
            int_sync <= '1;
            sda_sync <= '1;
        end else begin
            // Pin synchronizers
            int_sync <= {int_sync[1:0], touch_int};
            sda_sync <= {sda_sync[0], sda_in};
            div_cnt  <= tick ? '0 : div_cnt + 1'b1;
            case (state)
                i2c_idle: begin
                    div_cnt <= '0;
                    // Start condition, SDA falls with SCL high
                    if (int_fall) begin
                        sda_oeb <= 1'b0;
                        state   <= i2c_start;
                    end
                end
                i2c_start: begin
                    if (tick) begin
                        scl     <= 1'b0;
                        half    <= 1'b0;
                        bit_cnt <= '0;
                        shift   <= {`T08_TOUCH_ADDR, 1'b0};
                        state   <= i2c_addr;
                    end
                end
                i2c_store: begin
                    if (touch_done) state <= i2c_idle;
                end
                default: begin
                    // Data changes one clock after SCL falls
                    if (!half && div_cnt == div_w'(1)) sda_oeb <= sda_bit;
                    // Repeated start pulls low, stop releases, both mid high half
                    if (half && div_cnt == div_w'(`T08_I2C_DIV / 2)) begin
                        if (state == i2c_restart) sda_oeb <= 1'b0;
                        if (state == i2c_stop) sda_oeb <= 1'b1;
                    end
                    if (tick && !half) begin
                        scl  <= 1'b1;
                        half <= 1'b1;
                    end
                    if (tick && half) begin
                        if (state == i2c_stop) begin
                            // Bus left idle, SCL stays high
                            state <= i2c_store;
                        end else begin
                            scl  <= 1'b0;
                            half <= 1'b0;
                            if (state == i2c_restart) begin
                                bit_cnt <= '0;
                                shift   <= {`T08_TOUCH_ADDR, 1'b1};
                                state   <= i2c_raddr;
                            end else if (bit_cnt != 4'd8) begin
                                // Shift out and sample in on the same edge
                                bit_cnt <= bit_cnt + 1'b1;
                                shift   <= {shift[6:0], sda_sync[1]};
                            end else begin
                                bit_cnt <= '0;
                                case (state)
                                    i2c_addr: begin
                                        shift <= `T08_TOUCH_REG;
                                        state <= i2c_reg;
                                    end
                                    i2c_reg: state <= i2c_restart;
                                    i2c_raddr: begin
                                        byte_cnt <= '0;
                                        state    <= i2c_read;
                                    end
                                    default: begin
                                        rx_word <= {rx_word[23:0], shift};
                                        if (byte_cnt == 2'd3) state <= i2c_stop;
                                        else byte_cnt <= byte_cnt + 1'b1;
                                    end
                                endcase
                            end
                        end
                    end
                end
            endcase
        end
    end

endmodule

`default_nettype wire

//--- t08_wb_arbiter.sv
// Wishbone arbiter
// Fixed priority between the touch store and the display read, one classic
// cycle at a time with a done pulse back to the owner
`timescale 1ns/100ps
`default_nettype none

module t08_wb_arbiter import t08_pkg::*; (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     en,
    input  logic     touch_req,
    input  wb_addr_t touch_addr,
    input  wb_data_t touch_wdata,
    output logic     touch_done,
    input  logic     disp_req,
    input  wb_addr_t disp_addr,
    output logic     disp_done,
    output wb_data_t rdata,
    output wb_addr_t adr_o,
    output wb_data_t dat_o,
    output wb_sel_t  sel_o,
    output logic     we_o,
    output logic     stb_o,
    output logic     cyc_o,
    input  wb_data_t dat_i,
    input  logic     ack_i
);
    grant_e owner;
    logic   cyc;

    // Only the touch reader writes
    assign we_o  = owner == grant_touch;
    assign adr_o = (owner == grant_touch) ? touch_addr : disp_addr;
    assign dat_o = touch_wdata;
    // Full words only
    assign sel_o = '1;
    assign cyc_o = cyc;
    assign stb_o = cyc;

    always_ff @(posedge clk) begin
        if (!rst_n || !en) begin
            owner      <= grant_none;
            cyc        <= 1'b0;
            touch_done <= 1'b0;
            disp_done  <= 1'b0;
        end else begin
            touch_done <= 1'b0;
            disp_done  <= 1'b0;
            case (owner)
                grant_none: begin
                    // Touch wins a tie
                    if (touch_req) begin
                        owner <= grant_touch;
                        cyc   <= 1'b1;
                    end else if (disp_req) begin
                        owner <= grant_display;
                        cyc   <= 1'b1;
                    end
                end
                default: begin
                    if (cyc && ack_i) begin
                        cyc        <= 1'b0;
                        touch_done <= owner == grant_touch;
                        disp_done  <= owner == grant_display;
                    end else if (!cyc) begin
                        // Done cycle, owner drops its request here
                        owner <= grant_none;
                    end
                end
            endcase
        end
    end

    // Read data, valid alongside disp_done
    always_ff @(posedge clk) begin
        if (cyc && ack_i) rdata <= dat_i;
    end

endmodule

`default_nettype wire

//--- tb_team_08.sv
// Team 08 testbench
// Wishbone memory model, LCD capture and directed tests for touch
// sampling, frame refresh, arbitration, back-pressure and enable drop
`timescale 1ns/100ps
`default_nettype none
`include "t08_params.svh"

module tb_team_08 import t08_pkg::*; ;
    localparam int words      = `T08_FB_WORDS;
    localparam int frame_len  = 1 + 4 * words;
    localparam int max_delay  = 40;
    // Worst case per refresh and per I2C read, with margin
    localparam int frame_cyc  = frame_len * 3 + words * (max_delay + 6);
    localparam int i2c_cyc    = 8 * 9 * 2 * `T08_I2C_DIV + 100;
    localparam int cycle_limit = 9 * frame_cyc + 2 * i2c_cyc + 2000;

    logic        clk;
    logic        rst_n;
    logic        en;
    logic        touch_int;
    wb_addr_t    adr_o;
    wb_data_t    dat_o;
    wb_sel_t     sel_o;
    logic        we_o;
    logic        stb_o;
    logic        cyc_o;
    wb_data_t    dat_i;
    logic        ack_i;
    logic [33:0] gpio_in;
    logic [33:0] gpio_out;
    logic [33:0] gpio_oeb;
    wire         sda;
    coord_t      touch_x;
    coord_t      touch_y;
    logic [7:0]  seen_waddr;
    logic [7:0]  seen_reg;
    logic [7:0]  seen_raddr;
    int          reads_done;

    // Memory model state and logs
    wb_data_t    fb [0:words-1];
    integer      seed = 38889;
    logic        slow_ack;
    int          fixed_delay;
    logic        in_cycle;
    int          delay_left;
    wb_addr_t    rd_q[$];
    wb_addr_t    wr_addr_q[$];
    wb_data_t    wr_data_q[$];
    logic        acc_we_q[$];
    lcd_byte_t   cap_data[$];
    logic        cap_dcx[$];
    int          checks;
    int          errors;
    int          cycles;
    int          i;
    int          w;

    pullup (sda);
    assign sda     = gpio_oeb[1] ? 1'bz : gpio_out[1];
    assign gpio_in = {32'h0, sda, touch_int};

    team_08 team_08_i (
        .clk(clk), .rst_n(rst_n), .en(en),
        .adr_o(adr_o), .dat_o(dat_o), .sel_o(sel_o), .we_o(we_o), .stb_o(stb_o),
        .cyc_o(cyc_o), .dat_i(dat_i), .ack_i(ack_i),
        .gpio_in(gpio_in), .gpio_out(gpio_out), .gpio_oeb(gpio_oeb)
    );

    tb_touch_model touch_model (
        .scl(gpio_out[2]), .sda(sda), .x_coord(touch_x), .y_coord(touch_y),
        .waddr(seen_waddr), .reg_ptr(seen_reg), .raddr(seen_raddr), .reads_done(reads_done)
    );

    // Pattern depends on every address bit
    function automatic wb_data_t fill_pattern(input wb_addr_t a);
        return (a * 32'h9e37_79b1) ^ {a[15:0], a[31:16]};
    endfunction

    function automatic wb_data_t mem_read(input wb_addr_t a);
        wb_addr_t off;
        off = (a - `T08_FB_BASE) >> 2;
        if (off < words) return fb[off];
        return 32'hdead_beef;
    endfunction

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= cycle_limit) begin
            $display("Timeout: run exceeded %0d cycles", cycle_limit);
            $display("Test failures found");
            $finish;
        end
    end

    // Wishbone slave, responds on the falling edge
    always @(negedge clk) begin
        if (ack_i || !cyc_o) begin
            ack_i    = 1'b0;
            in_cycle = 1'b0;
        end else if (stb_o) begin
            if (!in_cycle) begin
                in_cycle   = 1'b1;
                delay_left = slow_ack ? {$random(seed)} % 6 : fixed_delay;
            end
            if (delay_left == 0) begin
                ack_i = 1'b1;
                acc_we_q.push_back(we_o);
                // Every access is a full word
                check_sel("sel_o", sel_o, 4'hf);
                if (we_o) begin
                    wr_addr_q.push_back(adr_o);
                    wr_data_q.push_back(dat_o);
                end else begin
                    rd_q.push_back(adr_o);
                    dat_i = mem_read(adr_o);
                end
            end else begin
                delay_left = delay_left - 1;
            end
        end
    end

    // LCD capture on each rising wrx
    always @(posedge gpio_out[11]) begin
        cap_data.push_back(gpio_out[10:3]);
        cap_dcx.push_back(gpio_out[14]);
    end

    task automatic check_byte(input string name, input lcd_byte_t got, input lcd_byte_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERR %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic check_word(input string name, input wb_data_t got, input wb_data_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERR %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic check_addr(input string name, input wb_addr_t got, input wb_addr_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERR %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic check_sel(input string name, input wb_sel_t got, input wb_sel_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERR %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERR %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic fail_plain(input string what);
        errors++;
        $display("%s", what);
    endtask

    task automatic clear_logs();
        rd_q.delete();
        wr_addr_q.delete();
        wr_data_q.delete();
        acc_we_q.delete();
        cap_data.delete();
        cap_dcx.delete();
    endtask

    // Frame bytes complete and panel deselected
    task automatic wait_frame(input int n_bytes);
        while (!(cap_data.size() >= n_bytes && gpio_out[13] === 1'b1)) @(posedge clk);
        repeat (4) @(posedge clk);
    endtask

    // Lower en for one clock, clear logs, raise again
    task automatic restart_enable();
        @(negedge clk) en = 1'b0;
        @(negedge clk) clear_logs();
        en = 1'b1;
    endtask

    task automatic check_frame(input int cap_base, input int rd_base);
        int wi;
        int b;
        lcd_byte_t exp;
        if (cap_data.size() < cap_base + frame_len || rd_q.size() < rd_base + words) begin
            fail_plain($sformatf("Frame incomplete: %0d bytes and %0d reads captured",
                                 cap_data.size(), rd_q.size()));
            return;
        end
        check_byte("lcd_data cmd", cap_data[cap_base], `T08_LCD_RAMWR);
        check_bit("dcx cmd", cap_dcx[cap_base], 1'b0);
        for (wi = 0; wi < words; wi++) begin
            for (b = 0; b < 4; b++) begin
                exp = fb[wi] >> (24 - 8 * b);
                check_byte($sformatf("lcd_data w%0d b%0d", wi, b),
                           cap_data[cap_base + 1 + 4 * wi + b], exp);
                check_bit("dcx data", cap_dcx[cap_base + 1 + 4 * wi + b], 1'b1);
            end
            check_addr($sformatf("read adr w%0d", wi), rd_q[rd_base + wi],
                       `T08_FB_BASE + 4 * wi);
        end
        check_bit("csx end", gpio_out[13], 1'b1);
    endtask

    task automatic check_idle();
        int p;
        check_bit("cyc_o", cyc_o, 1'b0);
        check_bit("stb_o", stb_o, 1'b0);
        check_bit("wrx", gpio_out[11], 1'b1);
        check_bit("rdx", gpio_out[12], 1'b1);
        check_bit("csx", gpio_out[13], 1'b1);
        check_bit("scl", gpio_out[2], 1'b1);
        check_bit("sda_oeb", gpio_oeb[1], 1'b1);
        check_bit("gpio_oeb[0]", gpio_oeb[0], 1'b1);
        for (p = 2; p <= 14; p++) check_bit($sformatf("gpio_oeb[%0d]", p), gpio_oeb[p], 1'b0);
        for (p = 15; p <= 33; p++) check_bit($sformatf("gpio_oeb[%0d]", p), gpio_oeb[p], 1'b1);
    endtask

    task automatic refresh_on_enable();
        @(negedge clk) clear_logs();
        en = 1'b1;
        wait_frame(frame_len);
        check_frame(0, 0);
    endtask

    task automatic touch_sample();
        int reads_before;
        touch_x = 12'h5a3;
        touch_y = 12'h1c7;
        reads_before = reads_done;
        @(negedge clk) clear_logs();
        touch_int = 1'b0;
        while (wr_addr_q.size() == 0) @(posedge clk);
        @(negedge clk) touch_int = 1'b1;
        wait_frame(frame_len);
        if (reads_done != reads_before + 1) fail_plain("Touch model saw no complete read");
        check_byte("i2c write address", seen_waddr, 8'h70);
        check_byte("i2c register", seen_reg, 8'h03);
        check_byte("i2c read address", seen_raddr, 8'h71);
        check_addr("store adr", wr_addr_q[0], `T08_TOUCH_BASE);
        check_word("store dat", wr_data_q[0], {4'h0, touch_y, 4'h0, touch_x});
        check_frame(0, 0);
        repeat (200) @(posedge clk);
        if (cap_data.size() != frame_len) fail_plain("Unexpected refresh after touch sample");
    endtask

    task automatic arbitration();
        int reads_before;
        touch_x     = 12'h0f1;
        touch_y     = 12'hc3e;
        fixed_delay = max_delay;
        reads_before = reads_done;
        @(negedge clk) en = 1'b0;
        @(negedge clk) clear_logs();
        en        = 1'b1;
        touch_int = 1'b0;
        wait_frame(2 * frame_len);
        @(negedge clk) touch_int = 1'b1;
        fixed_delay = 0;
        if (reads_done != reads_before + 1) fail_plain("Touch model saw no complete read");
        if (wr_addr_q.size() != 1 || acc_we_q.size() != 2 * words + 1) begin
            fail_plain($sformatf("Wrong access count: %0d writes, %0d accesses",
                                 wr_addr_q.size(), acc_we_q.size()));
        end else begin
            check_word("store dat", wr_data_q[0], {4'h0, touch_y, 4'h0, touch_x});
            w = -1;
            for (i = 0; i < acc_we_q.size(); i++) if (acc_we_q[i]) w = i;
            if (w <= 0 || w >= words) fail_plain("Touch store not inside the first frame");
        end
        check_frame(0, 0);
        check_frame(frame_len, words);
        repeat (200) @(posedge clk);
        if (cap_data.size() != 2 * frame_len) fail_plain("More than one extra refresh");
    endtask

    task automatic back_pressure();
        slow_ack = 1'b1;
        restart_enable();
        wait_frame(frame_len);
        check_frame(0, 0);
        slow_ack = 1'b0;
    endtask

    task automatic enable_drop();
        restart_enable();
        while (cap_data.size() < 20) @(posedge clk);
        @(negedge clk) en = 1'b0;
        repeat (3) @(negedge clk);
        check_idle();
        clear_logs();
        en = 1'b1;
        wait_frame(frame_len);
        check_frame(0, 0);
    endtask

    initial begin
        rst_n       = 1'b0;
        en          = 1'b0;
        touch_int   = 1'b1;
        ack_i       = 1'b0;
        dat_i       = '0;
        touch_x     = '0;
        touch_y     = '0;
        slow_ack    = 1'b0;
        fixed_delay = 0;
        in_cycle    = 1'b0;
        delay_left  = 0;
        checks      = 0;
        errors      = 0;
        cycles      = 0;
        for (i = 0; i < words; i++) fb[i] = fill_pattern(`T08_FB_BASE + 4 * i);
        repeat (3) @(negedge clk);
        rst_n = 1'b1;
        repeat (2) @(negedge clk);
        check_idle();
        refresh_on_enable();
        touch_sample();
        arbitration();
        back_pressure();
        enable_drop();
        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- tb_touch_model.sv
// Touch controller model
// I2C target with a register pointer; registers 3 to 6 return the
// programmed X/Y pair as XH, XL, YH, YL
`timescale 1ns/100ps
`default_nettype none

module tb_touch_model (
    input  wire         scl,
    inout  wire         sda,
    input  logic [11:0] x_coord,
    input  logic [11:0] y_coord,
    output logic [7:0]  waddr,
    output logic [7:0]  reg_ptr,
    output logic [7:0]  raddr,
    output int          reads_done
);
    logic       sda_low;
    logic [7:0] ptr;
    int         k;

    // Open drain, never drives high
    assign sda = sda_low ? 1'b0 : 1'bz;

    // Register file view, event flag in the XH/YH top bits
    function automatic logic [7:0] reg_value(input logic [7:0] addr);
        case (addr)
            8'h03:   return {4'b1000, x_coord[11:8]};
            8'h04:   return x_coord[7:0];
            8'h05:   return {4'b1000, y_coord[11:8]};
            8'h06:   return y_coord[7:0];
            default: return 8'h00;
        endcase
    endfunction

    // Start or repeated start, SDA falling while SCL high
    task automatic wait_start();
        do begin
            @(negedge sda);
        end while (scl !== 1'b1);
    endtask

    // Eight bits in on rising SCL, then ACK for one bit time
    task automatic recv_byte(output logic [7:0] b);
        int i;
        b = 8'h00;
        for (i = 0; i < 8; i++) begin
            @(posedge scl);
            b = {b[6:0], sda};
        end
        @(negedge scl);
        sda_low = 1'b1;
        @(negedge scl);
        sda_low = 1'b0;
    endtask

    // MSB first, bits change after SCL falls
    task automatic send_byte(input logic [7:0] b);
        int i;
        for (i = 7; i >= 0; i--) begin
            sda_low = !b[i];
            @(negedge scl);
        end
        // Master ACK or NACK slot
        sda_low = 1'b0;
        @(negedge scl);
    endtask

    initial begin
        sda_low    = 1'b0;
        reads_done = 0;
        waddr      = 8'h00;
        reg_ptr    = 8'h00;
        raddr      = 8'h00;
        ptr        = 8'h00;
        forever begin
            wait_start();
            recv_byte(waddr);
            // Pointer write, then repeated start for the read
            recv_byte(reg_ptr);
            ptr = reg_ptr;
            wait_start();
            recv_byte(raddr);
            for (k = 0; k < 4; k++) begin
                send_byte(reg_value(ptr));
                ptr = ptr + 8'h01;
            end
            reads_done = reads_done + 1;
        end
    end

endmodule

`default_nettype wire

//--- team_08.sv
// Team 08 user area top
// Touchscreen sampling over I2C with a parallel LCD refresh from memory,
// both sharing the one Wishbone master port
`timescale 1ns/100ps
`default_nettype none

module team_08 import t08_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        en,
    // Wishbone master
    output wb_addr_t    adr_o,
    output wb_data_t    dat_o,
    output wb_sel_t     sel_o,
    output logic        we_o,
    output logic        stb_o,
    output logic        cyc_o,
    input  wb_data_t    dat_i,
    input  logic        ack_i,
    // Breakout pins
    input  logic [33:0] gpio_in,
    output logic [33:0] gpio_out,
    output logic [33:0] gpio_oeb
);
    // Touch reader to arbiter
    logic      touch_req;
    wb_addr_t  touch_addr;
    wb_data_t  touch_wdata;
    logic      touch_done;
    // Display fetch to arbiter
    logic      disp_req;
    wb_addr_t  disp_addr;
    logic      disp_done;
    wb_data_t  rdata;
    // Display fetch to LCD bus
    logic      byte_strobe;
    logic      byte_is_cmd;
    logic      frame_active;
    lcd_byte_t byte_data;
    logic      lcd_busy;

    // Pin 0 interrupt in, pin 1 SDA follows the reader, 15 up unused
    assign gpio_oeb[33:15] = '1;
    assign gpio_oeb[14:2]  = '0;
    assign gpio_oeb[0]     = 1'b1;
    assign gpio_out[33:15] = '0;
    assign gpio_out[0]     = 1'b0;
    // Write-only panel, read strobe parked
    assign gpio_out[12]    = 1'b1;

    t08_touch_reader touch (
        .clk(clk), .rst_n(rst_n), .en(en),
        .touch_int(gpio_in[0]), .sda_in(gpio_in[1]),
        .sda_out(gpio_out[1]), .sda_oeb(gpio_oeb[1]), .scl(gpio_out[2]),
        .touch_req(touch_req), .touch_addr(touch_addr),
        .touch_wdata(touch_wdata), .touch_done(touch_done)
    );

    t08_display_fetch fetch (
        .clk(clk), .rst_n(rst_n), .en(en), .sample_stored(touch_done),
        .disp_req(disp_req), .disp_addr(disp_addr), .disp_done(disp_done), .rdata(rdata),
        .byte_strobe(byte_strobe), .byte_is_cmd(byte_is_cmd), .frame_active(frame_active),
        .byte_data(byte_data), .lcd_busy(lcd_busy)
    );

    t08_lcd_bus lcd (
        .clk(clk), .rst_n(rst_n), .en(en),
        .byte_strobe(byte_strobe), .byte_is_cmd(byte_is_cmd), .frame_active(frame_active),
        .byte_data(byte_data), .lcd_busy(lcd_busy),
        .wrx(gpio_out[11]), .csx(gpio_out[13]), .dcx(gpio_out[14]), .lcd_data(gpio_out[10:3])
    );

    t08_wb_arbiter arb (
        .clk(clk), .rst_n(rst_n), .en(en),
        .touch_req(touch_req), .touch_addr(touch_addr), .touch_wdata(touch_wdata),
        .touch_done(touch_done),
        .disp_req(disp_req), .disp_addr(disp_addr), .disp_done(disp_done), .rdata(rdata),
        .adr_o(adr_o), .dat_o(dat_o), .sel_o(sel_o), .we_o(we_o), .stb_o(stb_o), .cyc_o(cyc_o),
        .dat_i(dat_i), .ack_i(ack_i)
    );

endmodule

`default_nettype wire
